// File: src/mcu_cfg_pkg.sv
/*
  Address map, APB types and GPIO pin/pad types. Each slave window is 0x100 bytes,
  and everything from 0x300 upward is unmapped.
*/
package mcu_cfg_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // slave windows
  localparam logic [ADDR_W-1:0] GPIO_AO_BASE   = 12'h000;
  localparam logic [ADDR_W-1:0] GPIO_MAIN_BASE = 12'h100;
  localparam logic [ADDR_W-1:0] PWR_BASE       = 12'h200;
  localparam logic [ADDR_W-1:0] WINDOW_SIZE    = 12'h100;

  // gpio register offsets inside a bank
  localparam logic [ADDR_W-1:0] GPIO_OUT_OFS         = 12'h000;
  localparam logic [ADDR_W-1:0] GPIO_OE_OFS          = 12'h004;
  localparam logic [ADDR_W-1:0] GPIO_IN_OFS          = 12'h008;
  localparam logic [ADDR_W-1:0] GPIO_INTR_EN_OFS     = 12'h00C;
  localparam logic [ADDR_W-1:0] GPIO_INTR_STATUS_OFS = 12'h010;

  localparam int GPIO_AO_PINS   = 8;
  localparam int GPIO_MAIN_PINS = 16;

  typedef logic [GPIO_AO_PINS-1:0] gpio_ao_pins_t;
  typedef logic [GPIO_MAIN_PINS-1:0] gpio_main_pins_t;

  typedef struct packed {
    gpio_ao_pins_t out;
    gpio_ao_pins_t oe;
  } gpio_ao_pad_t;

  typedef struct packed {
    gpio_main_pins_t out;
    gpio_main_pins_t oe;
  } gpio_main_pad_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

// File: src/mcu_pwr_pkg.sv
/*
  Power control bundle, sequencer states and power register layout.
  All control bits are active high.
*/
package mcu_pwr_pkg;

  typedef struct packed {
    logic switch_off;
    logic iso_en;
    logic rst_en;
  } pwr_ctrl_t;

  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_RST,
    PWR_SWOFF,
    PWR_OFF,
    PWR_SWON,
    PWR_UNRST,
    PWR_UNISO
  } pwr_state_e;

  // register offsets inside the power window
  localparam logic [mcu_cfg_pkg::ADDR_W-1:0] PWR_CTRL_OFS   = 12'h000;
  localparam logic [mcu_cfg_pkg::ADDR_W-1:0] PWR_STATUS_OFS = 12'h004;

  // control register bits
  localparam int PWR_OFF_REQ_BIT = 0;
  localparam int PWR_WAKE_EN_BIT = 1;

  // status register layout
  localparam int PWR_STATUS_OFF_BIT   = 0;
  localparam int PWR_STATUS_STATE_LSB = 4;

endpackage

// File: src/apb_decoder.sv
/*
  Purely combinational. Slaves see the offset inside their window only;
  unmapped addresses get pready with pslverr and zero prdata.
*/
module apb_decoder
  import mcu_cfg_pkg::*;
(
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o,

  output apb_req_t ao_req_o,
  input  apb_rsp_t ao_rsp_i,

  output apb_req_t main_req_o,
  input  apb_rsp_t main_rsp_i,

  output apb_req_t pwr_req_o,
  input  apb_rsp_t pwr_rsp_i
);

  logic [ADDR_W-1:0] win_base;
  logic [ADDR_W-1:0] win_ofs;
  logic              sel_ao;
  logic              sel_main;
  logic              sel_pwr;

  assign win_base = req_i.paddr & ~(WINDOW_SIZE - 1'b1);
  assign win_ofs  = req_i.paddr & (WINDOW_SIZE - 1'b1);

  assign sel_ao   = (win_base == GPIO_AO_BASE);
  assign sel_main = (win_base == GPIO_MAIN_BASE);
  assign sel_pwr  = (win_base == PWR_BASE);

  // only the selected slave sees psel
  always_comb begin
    ao_req_o         = req_i;
    ao_req_o.paddr   = win_ofs;
    ao_req_o.psel    = req_i.psel & sel_ao;
    main_req_o       = req_i;
    main_req_o.paddr = win_ofs;
    main_req_o.psel  = req_i.psel & sel_main;
    pwr_req_o        = req_i;
    pwr_req_o.paddr  = win_ofs;
    pwr_req_o.psel   = req_i.psel & sel_pwr;
  end

  always_comb begin
    if (sel_ao) begin
      rsp_o = ao_rsp_i;
    end else if (sel_main) begin
      rsp_o = main_rsp_i;
    end else if (sel_pwr) begin
      rsp_o = pwr_rsp_i;
    end else begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = 1'b1;
      rsp_o.pslverr = 1'b1;
    end
  end

endmodule

// File: src/gpio_bank.sv
/*
  Zero wait-state APB slave; unused offsets read zero without error.
  Status bits set 3 cycles after an input rises. Sync chain is free-running, so a pin
  already high when reset releases raises no interrupt.
*/
module gpio_bank
  import mcu_cfg_pkg::*;
#(
  parameter type pins_t = gpio_ao_pins_t,
  parameter type pad_t  = gpio_ao_pad_t
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o,
  input  pins_t    pins_i,
  output pad_t     pad_o,
  output logic     irq_o
);

  pins_t out_q;
  pins_t oe_q;
  pins_t ie_q;
  pins_t status_q;
  pins_t sync1_q;
  pins_t sync2_q;
  pins_t prev_q;
  pins_t wdata;
  pins_t rise;
  pins_t clr;
  logic  wr_en;

  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;
  assign wdata = req_i.pwdata[$bits(pins_t)-1:0];
  assign rise  = sync2_q & ~prev_q;
  assign clr   = (wr_en && req_i.paddr == GPIO_INTR_STATUS_OFS) ? wdata : '0;

  // two-flop synchronizer, then the edge register
  always_ff @(posedge clk_i) begin
    sync1_q <= pins_i;
    sync2_q <= sync1_q;
    prev_q  <= sync2_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      ie_q     <= '0;
      status_q <= '0;
    end else begin
      if (wr_en && req_i.paddr == GPIO_OUT_OFS) begin
        out_q <= wdata;
      end
      if (wr_en && req_i.paddr == GPIO_OE_OFS) begin
        oe_q <= wdata;
      end
      if (wr_en && req_i.paddr == GPIO_INTR_EN_OFS) begin
        ie_q <= wdata;
      end
      // new edge wins over a clear in the same cycle
      status_q <= (status_q & ~clr) | rise;
    end
  end

  always_comb begin
    rsp_o        = '0;
    rsp_o.pready = 1'b1;
    case (req_i.paddr)
      GPIO_OUT_OFS:         rsp_o.prdata = DATA_W'(out_q);
      GPIO_OE_OFS:          rsp_o.prdata = DATA_W'(oe_q);
      GPIO_IN_OFS:          rsp_o.prdata = DATA_W'(sync2_q);
      GPIO_INTR_EN_OFS:     rsp_o.prdata = DATA_W'(ie_q);
      GPIO_INTR_STATUS_OFS: rsp_o.prdata = DATA_W'(status_q);
      default:              rsp_o.prdata = '0;
    endcase
  end

  assign pad_o.out = out_q;
  assign pad_o.oe  = oe_q;

  assign irq_o = |(status_q & ie_q);

endmodule

// File: src/gated_periph_domain.sv
/*
  Power-gated island with the main GPIO bank. While iso_en is high the pads and irq are
  clamped low and every access answers pslverr. rst_en holds the bank in reset.
*/
module gated_periph_domain
  import mcu_cfg_pkg::*;
  import mcu_pwr_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  apb_req_t        req_i,
  output apb_rsp_t        rsp_o,
  input  pwr_ctrl_t       pwr_i,
  input  gpio_main_pins_t pins_i,
  output gpio_main_pad_t  pad_o,
  output logic            irq_o
);

  apb_req_t       bank_req;
  apb_rsp_t       bank_rsp;
  gpio_main_pad_t bank_pad;
  logic           bank_irq;
  logic           bank_reset;

  // bank comes back with reset values after a power cycle
  assign bank_reset = reset_i | pwr_i.rst_en;

  always_comb begin
    bank_req      = req_i;
    bank_req.psel = req_i.psel & ~pwr_i.iso_en;
  end

  gpio_bank #(
    .pins_t(gpio_main_pins_t),
    .pad_t (gpio_main_pad_t)
  ) gpio_main_bank_i (
    .clk_i  (clk_i),
    .reset_i(bank_reset),
    .req_i  (bank_req),
    .rsp_o  (bank_rsp),
    .pins_i (pins_i),
    .pad_o  (bank_pad),
    .irq_o  (bank_irq)
  );

  // isolation clamps
  always_comb begin
    if (pwr_i.iso_en) begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = 1'b1;
      rsp_o.pslverr = 1'b1;
      pad_o         = '0;
    end else begin
      rsp_o = bank_rsp;
      pad_o = bank_pad;
    end
  end

  assign irq_o = bank_irq & ~pwr_i.iso_en;

endmodule

// File: src/power_manager.sv
/*
  One state per cycle except SWOFF and SWON, which wait on pwr_ack_i (high = powered).
  Off request starts the off sequence; clearing it, or a wake with wake enable, powers up.
*/
module power_manager
  import mcu_cfg_pkg::*;
  import mcu_pwr_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  apb_req_t  req_i,
  output apb_rsp_t  rsp_o,
  input  logic      wake_i,
  input  logic      pwr_ack_i,
  output pwr_ctrl_t pwr_ctrl_o
);

  pwr_state_e state_q;
  pwr_state_e state_d;
  logic       off_req_q;
  logic       wake_en_q;
  logic       wr_ctrl;
  logic       wake;

  assign wr_ctrl = req_i.psel & req_i.penable & req_i.pwrite &
                   (req_i.paddr == PWR_CTRL_OFS);
  assign wake    = wake_en_q & wake_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      off_req_q <= 1'b0;
      wake_en_q <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        off_req_q <= req_i.pwdata[PWR_OFF_REQ_BIT];
        wake_en_q <= req_i.pwdata[PWR_WAKE_EN_BIT];
      end
      // wake drops the off request, even over a write
      if (state_q == PWR_OFF && wake) begin
        off_req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= PWR_ON;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ON:    if (off_req_q) state_d = PWR_ISO;
      PWR_ISO:   state_d = PWR_RST;
      PWR_RST:   state_d = PWR_SWOFF;
      PWR_SWOFF: if (!pwr_ack_i) state_d = PWR_OFF;
      PWR_OFF:   if (!off_req_q || wake) state_d = PWR_SWON;
      PWR_SWON:  if (pwr_ack_i) state_d = PWR_UNRST;
      PWR_UNRST: state_d = PWR_UNISO;
      PWR_UNISO: state_d = PWR_ON;
      default:   state_d = PWR_ON;
    endcase
  end

  // control bundle decoded from the state
  always_comb begin
    pwr_ctrl_o = '0;
    case (state_q)
      PWR_ISO, PWR_UNRST: begin
        pwr_ctrl_o.iso_en = 1'b1;
      end
      PWR_RST, PWR_SWON: begin
        pwr_ctrl_o.iso_en = 1'b1;
        pwr_ctrl_o.rst_en = 1'b1;
      end
      PWR_SWOFF, PWR_OFF: begin
        pwr_ctrl_o.iso_en     = 1'b1;
        pwr_ctrl_o.rst_en     = 1'b1;
        pwr_ctrl_o.switch_off = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    rsp_o        = '0;
    rsp_o.pready = 1'b1;
    case (req_i.paddr)
      PWR_CTRL_OFS: begin
        rsp_o.prdata[PWR_OFF_REQ_BIT] = off_req_q;
        rsp_o.prdata[PWR_WAKE_EN_BIT] = wake_en_q;
      end
      PWR_STATUS_OFS: begin
        rsp_o.prdata[PWR_STATUS_OFF_BIT] = (state_q == PWR_OFF);
        rsp_o.prdata[PWR_STATUS_STATE_LSB +: $bits(pwr_state_e)] = state_q;
      end
      default: ;
    endcase
  end

endmodule

// File: src/mcu_periph_top.sv
/*
  Always-on GPIO (irq bit 0), gated main GPIO (irq bit 1) and the power manager on one APB.
  pwr_ack_i must be high while the gated domain is powered.
*/
module mcu_periph_top
  import mcu_cfg_pkg::*;
  import mcu_pwr_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  apb_req_t        apb_req_i,
  output apb_rsp_t        apb_rsp_o,
  input  gpio_ao_pins_t   gpio_ao_i,
  output gpio_ao_pad_t    gpio_ao_o,
  input  gpio_main_pins_t gpio_main_i,
  output gpio_main_pad_t  gpio_main_o,
  output pwr_ctrl_t       pwr_ctrl_o,
  input  logic            pwr_ack_i,
  output logic [1:0]      irq_o
);

  apb_req_t ao_req;
  apb_rsp_t ao_rsp;
  apb_req_t main_req;
  apb_rsp_t main_rsp;
  apb_req_t pwr_req;
  apb_rsp_t pwr_rsp;

  apb_decoder apb_decoder_i (
    .req_i     (apb_req_i),
    .rsp_o     (apb_rsp_o),
    .ao_req_o  (ao_req),
    .ao_rsp_i  (ao_rsp),
    .main_req_o(main_req),
    .main_rsp_i(main_rsp),
    .pwr_req_o (pwr_req),
    .pwr_rsp_i (pwr_rsp)
  );

  gpio_bank #(
    .pins_t(gpio_ao_pins_t),
    .pad_t (gpio_ao_pad_t)
  ) gpio_ao_bank_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (ao_req),
    .rsp_o  (ao_rsp),
    .pins_i (gpio_ao_i),
    .pad_o  (gpio_ao_o),
    .irq_o  (irq_o[0])
  );

  gated_periph_domain gated_periph_domain_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (main_req),
    .rsp_o  (main_rsp),
    .pwr_i  (pwr_ctrl_o),
    .pins_i (gpio_main_i),
    .pad_o  (gpio_main_o),
    .irq_o  (irq_o[1])
  );

  // always-on interrupt doubles as the wake source
  power_manager power_manager_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (pwr_req),
    .rsp_o     (pwr_rsp),
    .wake_i    (irq_o[0]),
    .pwr_ack_i (pwr_ack_i),
    .pwr_ctrl_o(pwr_ctrl_o)
  );

endmodule

// File: verification/tb_clkgen.sv
/*
  Free-running clock with a period of 40; reset held high for the first 4 rising edges.
*/
module tb_clkgen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: verification/mcu_pwr_props.sv
/*
  Checks on the power sequencer outputs and its APB slave port. Attached by bind.
*/
module mcu_pwr_props
  import mcu_cfg_pkg::*;
  import mcu_pwr_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input apb_req_t  req_i,
  input apb_rsp_t  rsp_i,
  input pwr_ctrl_t pwr_ctrl_i
);

  // switch may only open behind isolation and reset
  a_switch_guarded: assert property (@(posedge clk_i) disable iff (reset_i)
    pwr_ctrl_i.switch_off |-> (pwr_ctrl_i.iso_en && pwr_ctrl_i.rst_en))
    else $error("switch_off high without iso_en and rst_en");

  a_rst_under_iso: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(pwr_ctrl_i.rst_en) |-> pwr_ctrl_i.iso_en)
    else $error("rst_en rose while iso_en was low");

  // zero wait states
  a_pready_access: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_i.psel && req_i.penable) |-> rsp_i.pready)
    else $error("pready low in an access cycle");

endmodule

bind power_manager mcu_pwr_props pwr_props_i (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .req_i     (req_i),
  .rsp_i     (rsp_o),
  .pwr_ctrl_i(pwr_ctrl_o)
);

// File: verification/mcu_tb.sv
/*
  Random stimulus from a fixed seed against a register model; bank 0 is always-on, bank 1
  is the gated main bank. pwr_ack_i follows switch_off after 1 to 8 cycles.
*/
module mcu_tb
  import mcu_cfg_pkg::*;
  import mcu_pwr_pkg::*;
;

  logic            clk_i;
  logic            reset_i;
  apb_req_t        apb_req_i;
  apb_rsp_t        apb_rsp_o;
  gpio_ao_pins_t   gpio_ao_i;
  gpio_ao_pad_t    gpio_ao_o;
  gpio_main_pins_t gpio_main_i;
  gpio_main_pad_t  gpio_main_o;
  pwr_ctrl_t       pwr_ctrl_o;
  logic            pwr_ack_i;
  logic [1:0]      irq_o;

  integer      seed = 32'he076a386;
  integer      cycles = 0;
  logic [15:0] m_out [2];
  logic [15:0] m_oe [2];
  logic [15:0] m_ie [2];
  logic [15:0] m_stat [2];
  logic [31:0] rdata;
  logic        slverr;
  logic [15:0] val;
  int          ack_delay;

  tb_clkgen clkgen_i (.clk_o(clk_i), .reset_o(reset_i));

  mcu_periph_top DUT (.*);

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // setup cycle, access cycle, sample mid-access, release on the closing edge
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wd,
                          output logic [31:0] rd, output logic err);
    @(posedge clk_i);
    apb_req_i <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wd};
    @(posedge clk_i);
    apb_req_i.penable <= 1'b1;
    @(negedge clk_i);
    while (!apb_rsp_o.pready) @(negedge clk_i);
    rd  = apb_rsp_o.prdata;
    err = apb_rsp_o.pslverr;
    @(posedge clk_i);
    apb_req_i.psel    <= 1'b0;
    apb_req_i.penable <= 1'b0;
  endtask

  task automatic reg_write(input string name, input logic [11:0] addr, input logic [31:0] wd);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, wd, rd, err);
    check({name, " write pslverr"}, 0, err);
  endtask

  task automatic reg_read(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 0, rd, err);
    check({name, " pslverr"}, 0, err);
    check(name, exp, rd);
  endtask

  task automatic set_pins(input int b, input logic [15:0] v);
    @(posedge clk_i);
    if (b == 0) gpio_ao_i <= v[7:0];
    else gpio_main_i <= v;
  endtask

  // each change of pwr_ctrl_o must be the next step of the expected order
  task automatic watch_seq(input string name, input logic [2:0] s1, input logic [2:0] s2,
                           input logic [2:0] s3);
    logic [2:0] prev;
    int         step;
    prev = pwr_ctrl_o;
    step = 0;
    while (step < 3) begin
      @(negedge clk_i);
      if (pwr_ctrl_o !== prev) begin
        check(name, (step == 0) ? s1 : (step == 1) ? s2 : s3, pwr_ctrl_o);
        prev = pwr_ctrl_o;
        step++;
      end
    end
  endtask

  // switch answers after a random delay
  initial begin
    forever begin
      @(posedge clk_i);
      if (pwr_ctrl_o.switch_off === pwr_ack_i) begin
        ack_delay = 1 + ($unsigned($random(seed)) % 8);
        repeat (ack_delay - 1) @(posedge clk_i);
        pwr_ack_i <= ~pwr_ctrl_o.switch_off;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 20000) begin
      $display("timeout: the tests did not finish within 20000 cycles");
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [11:0] base;
    logic [15:0] mask;
    logic [15:0] clr;
    apb_req_i   = '0;
    gpio_ao_i   = '0;
    gpio_main_i = '0;
    pwr_ack_i   = 1'b1;
    for (int b = 0; b < 2; b++) begin
      m_out[b]  = '0;
      m_oe[b]   = '0;
      m_ie[b]   = '0;
      m_stat[b] = '0;
    end
    wait (reset_i === 1'b0);
    @(negedge clk_i);

    // after reset
    check("reset ao pad", 0, gpio_ao_o);
    check("reset main pad", 0, gpio_main_o);
    check("reset pwr_ctrl", 0, pwr_ctrl_o);
    check("reset irq", 0, irq_o);
    reg_read("reset pwr status", 12'h204, 32'h0);

    // register access and pin inputs
    for (int b = 0; b < 2; b++) begin
      base = (b == 0) ? 12'h000 : 12'h100;
      mask = (b == 0) ? 16'h00ff : 16'hffff;
      for (int i = 0; i < 40; i++) begin
        m_out[b] = $random(seed) & mask;
        m_oe[b]  = $random(seed) & mask;
        m_ie[b]  = $random(seed) & mask;
        reg_write("out", base + 12'h0, m_out[b]);
        reg_write("oe", base + 12'h4, m_oe[b]);
        reg_write("intr_en", base + 12'hc, m_ie[b]);
        reg_read("out readback", base + 12'h0, m_out[b]);
        reg_read("oe readback", base + 12'h4, m_oe[b]);
        reg_read("intr_en readback", base + 12'hc, m_ie[b]);
        check("pad out", m_out[b], (b == 0) ? gpio_ao_o.out : gpio_main_o.out);
        check("pad oe", m_oe[b], (b == 0) ? gpio_ao_o.oe : gpio_main_o.oe);
        val = $random(seed) & mask;
        set_pins(b, val);
        repeat (4) @(posedge clk_i);
        reg_read("in", base + 12'h8, val);
      end
    end

    // rising-edge interrupts
    for (int b = 0; b < 2; b++) begin
      base = (b == 0) ? 12'h000 : 12'h100;
      mask = (b == 0) ? 16'h00ff : 16'hffff;
      for (int i = 0; i < 30; i++) begin
        set_pins(b, 0);
        repeat (4) @(posedge clk_i);
        reg_write("status clear all", base + 12'h10, mask);
        m_stat[b] = '0;
        m_ie[b]   = $random(seed) & mask;
        reg_write("intr_en", base + 12'hc, m_ie[b]);
        val = $random(seed) & mask;
        set_pins(b, val);
        repeat (4) @(posedge clk_i);
        m_stat[b] = m_stat[b] | val;
        reg_read("status after edge", base + 12'h10, m_stat[b]);
        check("irq after edge", |(m_stat[b] & m_ie[b]), irq_o[b]);
        clr = $random(seed) & mask;
        reg_write("status clear", base + 12'h10, clr);
        m_stat[b] = m_stat[b] & ~clr;
        reg_read("status after clear", base + 12'h10, m_stat[b]);
        @(negedge clk_i);
        check("irq after clear", |(m_stat[b] & m_ie[b]), irq_o[b]);
      end
      set_pins(b, 0);
      repeat (4) @(posedge clk_i);
      reg_write("status clear all", base + 12'h10, mask);
      m_stat[b] = '0;
    end

    // pending main interrupt before power-off
    m_ie[1] = 16'hffff;
    reg_write("main intr_en", 12'h10c, m_ie[1]);
    val = $random(seed) | 16'h0001;
    set_pins(1, val);
    repeat (4) @(posedge clk_i);
    m_stat[1] = val;
    reg_read("main status before off", 12'h110, m_stat[1]);
    check("main irq before off", |(m_stat[1] & m_ie[1]), irq_o[1]);

    // power off by request
    reg_write("pwr ctrl off", 12'h200, 32'h1);
    watch_seq("off order", 3'b010, 3'b011, 3'b111);
    rdata = 0;
    while (!rdata[0]) apb_xfer(1'b0, 12'h204, 0, rdata, slverr);
    check("status in off", 32'h41, rdata);
    check("main pad off", 0, gpio_main_o);
    check("main irq off", 0, irq_o[1]);
    apb_xfer(1'b0, 12'h100, 0, rdata, slverr);
    check("main read pslverr", 1, slverr);
    check("main read prdata", 0, rdata);
    apb_xfer(1'b1, 12'h104, 32'hffff, rdata, slverr);
    check("main write pslverr", 1, slverr);
    m_out[0] = $random(seed) & 16'h00ff;
    reg_write("ao out while off", 12'h000, m_out[0]);
    reg_read("ao out while off", 12'h000, m_out[0]);

    // power on by clearing the request
    reg_write("pwr ctrl on", 12'h200, 32'h0);
    watch_seq("on order", 3'b011, 3'b010, 3'b000);
    reg_read("status on", 12'h204, 32'h0);
    for (int a = 0; a < 5; a++) begin
      if (a != 2) reg_read("main reset value", 12'h100 + 12'(a * 4), 32'h0);
    end

    // non-reset main contents again before the second power cycle
    m_out[1] = $random(seed) | 16'h0001;
    m_oe[1]  = $random(seed) | 16'h0001;
    reg_write("main out", 12'h100, m_out[1]);
    reg_write("main oe", 12'h104, m_oe[1]);
    reg_write("main intr_en", 12'h10c, m_ie[1]);
    check("main pad before wake cycle", {m_out[1], m_oe[1]}, gpio_main_o);

    // power off with wake enabled, then wake through an always-on edge
    m_ie[0] = 16'h0001;
    reg_write("ao intr_en", 12'h00c, m_ie[0]);
    reg_write("pwr ctrl off wake", 12'h200, 32'h3);
    watch_seq("off order wake", 3'b010, 3'b011, 3'b111);
    rdata = 0;
    while (!rdata[0]) apb_xfer(1'b0, 12'h204, 0, rdata, slverr);
    set_pins(0, 16'h0001);
    m_stat[0] = 16'h0001;
    watch_seq("wake order", 3'b011, 3'b010, 3'b000);
    reg_read("ctrl after wake", 12'h200, 32'h2);
    reg_read("ao status after wake", 12'h010, m_stat[0]);
    for (int a = 0; a < 5; a++) begin
      if (a != 2) reg_read("main reset value after wake", 12'h100 + 12'(a * 4), 32'h0);
    end
    check("main pad after wake", 0, gpio_main_o);

    // unmapped space
    for (int i = 0; i < 30; i++) begin
      base = 12'h300 + ($unsigned($random(seed)) % 12'hd00);
      apb_xfer(i[0], base, $random(seed), rdata, slverr);
      check("unmapped pslverr", 1, slverr);
      check("unmapped prdata", 0, rdata);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: all.f
src/mcu_cfg_pkg.sv
src/mcu_pwr_pkg.sv
src/apb_decoder.sv
src/gpio_bank.sv
src/gated_periph_domain.sv
src/power_manager.sv
src/mcu_periph_top.sv
verification/tb_clkgen.sv
verification/mcu_pwr_props.sv
verification/mcu_tb.sv
